/* src/mem_pkg.sv */
package mem_pkg;

    // pipeline side widths
    localparam int DATA_W   = 32;  // register / alu word
    localparam int HALF_W   = 16;  // external sram data bus
    localparam int BE_W     = HALF_W / 8;  // byte lanes per half

    // sram addressing
    // word address lives in alu_result[20:2], sram_addr[0] picks the half
    localparam int SRAM_AW  = 20;
    localparam int WORD_AW  = SRAM_AW - 1;  // word part of sram_addr
    localparam int WORD_LSB = 2;  // byte offset bits below this are ignored

    // access size from decode
    typedef enum logic [1:0] {
        SEL_NONE = 2'b00,  // no transfer, finishes in one cycle
        SEL_BYTE = 2'b01,  // sb / lb, low lane of half 0
        SEL_HALF = 2'b10,  // sh / lh, both lanes of half 0
        SEL_WORD = 2'b11   // sw / lw, half 0 then half 1
    } mem_sel_e;

    // bus request from mem_ctrl to sram_port, valid for one setup cycle
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_READ  = 2'b01,
        OP_WRITE = 2'b10
    } sram_op_e;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,  // waiting for mem_read / mem_write
        ST_SETUP  = 2'b01,  // bus registers load addr, data, strobes
        ST_STROBE = 2'b10,  // ce active, write edge / read capture at end
        ST_DONE   = 2'b11   // mem_done pulse
    } ctrl_state_e;

endpackage

/* src/mem_ctrl.sv */
`timescale 1ns/10ps

module mem_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_read,   // load request, held until mem_done
    input  logic               mem_write,  // store request, held until mem_done
    input  mem_pkg::mem_sel_e  mem_sel,
    output mem_pkg::sram_op_e  op,         // to sram_port
    output logic               half_sel,   // 0 = low half, 1 = high half
    output logic               capture,    // latch sram_rdata this edge
    output logic               stall,
    output logic               mem_done
);
    import mem_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_nxt;
    logic        req;        // any request from the pipeline
    logic        is_write;   // direction, sampled in idle
    logic        half_cnt;   // which half is on the bus
    logic        last_half;  // no more halves after this strobe

    assign req = mem_read | mem_write;

    // only word accesses need a second half
    assign last_half = (mem_sel != SEL_WORD) | half_cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req) begin
                    // nothing to move on the bus for SEL_NONE
                    if (mem_sel == SEL_NONE)
                        state_nxt = ST_DONE;
                    else
                        state_nxt = ST_SETUP;
                end
            end
            ST_SETUP:  state_nxt = ST_STROBE;
            ST_STROBE: state_nxt = last_half ? ST_DONE : ST_SETUP;  // loop for half 1
            ST_DONE:   state_nxt = ST_IDLE;  // pipeline moves on next cycle
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            half_cnt <= 1'b0;
            is_write <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == ST_IDLE) begin
                half_cnt <= 1'b0;
                is_write <= mem_write;  // store wins if both are raised
            end else if (state == ST_STROBE && !last_half) begin
                half_cnt <= 1'b1;  // first half of a word finished
            end
        end
    end

    // bus request is issued only in setup, port registers it for the strobe
    always_comb begin
        op = OP_IDLE;
        if (state == ST_SETUP) begin
            if (is_write)
                op = OP_WRITE;
            else
                op = OP_READ;
        end
    end

    assign half_sel = half_cnt;

    // read data is valid on the bus through the whole strobe cycle
    assign capture = (state == ST_STROBE) & ~is_write;

    assign mem_done = (state == ST_DONE);

    // hold the pipeline until the done pulse
    assign stall = req & ~mem_done;

endmodule

/* src/store_format.sv */
`timescale 1ns/10ps

module store_format (
    input  logic [mem_pkg::DATA_W-1:0] din,         // rs2 store data
    input  mem_pkg::mem_sel_e          mem_sel,
    input  logic                       half_sel,    // half currently sequenced
    output logic [mem_pkg::HALF_W-1:0] half_wdata,  // to sram_port
    output logic [mem_pkg::BE_W-1:0]   half_be      // byte lanes, bit 0 = low byte
);
    import mem_pkg::*;

    // little endian, half 0 holds din[15:0]
    always_comb begin
        half_wdata = '0;
        half_be    = '0;
        case (mem_sel)
            SEL_BYTE: begin
                half_wdata = {{(HALF_W-8){1'b0}}, din[7:0]};
                half_be    = 2'b01;  // low lane only
            end
            SEL_HALF: begin
                half_wdata = din[HALF_W-1:0];
                half_be    = '1;
            end
            SEL_WORD: begin
                // two passes, low half first
                if (half_sel)
                    half_wdata = din[DATA_W-1:HALF_W];
                else
                    half_wdata = din[HALF_W-1:0];
                half_be = '1;
            end
            default: begin
                half_wdata = '0;  // SEL_NONE, nothing written
                half_be    = '0;
            end
        endcase
    end

endmodule

/* src/sram_port.sv */
`timescale 1ns/10ps

module sram_port (
    input  logic                        clk,
    input  logic                        rst,
    input  mem_pkg::sram_op_e           op,          // from mem_ctrl, setup cycle only
    input  logic                        half_sel,
    input  logic                        capture,
    input  logic [mem_pkg::WORD_AW-1:0] word_addr,   // alu_result[20:2]
    input  logic [mem_pkg::HALF_W-1:0]  half_wdata,
    input  logic [mem_pkg::BE_W-1:0]    half_be,
    input  logic [mem_pkg::HALF_W-1:0]  sram_rdata,  // async read data
    output logic [mem_pkg::SRAM_AW-1:0] sram_addr,
    output logic [mem_pkg::HALF_W-1:0]  sram_wdata,
    output logic [mem_pkg::BE_W-1:0]    sram_be,
    output logic                        ce,
    output logic                        we,
    output logic                        oe,
    output logic [mem_pkg::DATA_W-1:0]  load_word    // assembled read data
);
    import mem_pkg::*;

    // strobes, registered so the sram sees clean levels
    // op lasts one cycle so ce/we/oe pulse for one strobe cycle per half
    always_ff @(posedge clk) begin
        if (rst) begin
            ce <= 1'b0;
            we <= 1'b0;
            oe <= 1'b0;
        end else begin
            ce <= (op != OP_IDLE);
            we <= (op == OP_WRITE);
            oe <= (op == OP_READ);
        end
    end

    // address and write data, loaded together with the strobes
    always_ff @(posedge clk) begin
        if (op != OP_IDLE) begin
            sram_addr  <= {word_addr, half_sel};
            sram_wdata <= half_wdata;
            if (op == OP_WRITE)
                sram_be <= half_be;
            else
                sram_be <= '1;  // reads drive all lanes
        end
    end

    // read assembly
    // upper half cleared on the first setup so short loads read back zero
    always_ff @(posedge clk) begin
        if (op == OP_READ && !half_sel)
            load_word[DATA_W-1:HALF_W] <= '0;
        if (capture) begin
            if (half_sel)
                load_word[DATA_W-1:HALF_W] <= sram_rdata;
            else
                load_word[HALF_W-1:0] <= sram_rdata;
        end
    end

endmodule

/* src/load_format.sv */
`timescale 1ns/10ps

module load_format (
    input  logic [mem_pkg::DATA_W-1:0] load_word,   // raw halves from sram_port
    input  logic [mem_pkg::DATA_W-1:0] alu_result,
    input  logic [mem_pkg::DATA_W-1:0] imme,
    input  mem_pkg::mem_sel_e          mem_sel,
    input  logic                       mem_to_reg,  // writeback takes memory data
    input  logic                       lui_sig,     // writeback takes imme << 16
    output logic [mem_pkg::DATA_W-1:0] dout         // writeback value
);
    import mem_pkg::*;

    logic [DATA_W-1:0] load_val;  // zero extended load result
    logic [DATA_W-1:0] lui_val;

    // zero extension only, no signed loads
    always_comb begin
        case (mem_sel)
            SEL_BYTE: load_val = {{(DATA_W-8){1'b0}}, load_word[7:0]};
            SEL_HALF: load_val = {{(DATA_W-HALF_W){1'b0}}, load_word[HALF_W-1:0]};
            SEL_WORD: load_val = load_word;
            default:  load_val = '0;  // SEL_NONE reads nothing
        endcase
    end

    assign lui_val = {imme[HALF_W-1:0], {HALF_W{1'b0}}};  // upper immediate

    // lui first, then load data, else pass the alu result through
    always_comb begin
        if (lui_sig)
            dout = lui_val;
        else if (mem_to_reg)
            dout = load_val;
        else
            dout = alu_result;
    end

endmodule

/* src/mem_stage.sv */
`timescale 1ns/10ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [mem_pkg::DATA_W-1:0]  alu_result,  // effective address or result
    input  logic [mem_pkg::DATA_W-1:0]  din,         // store data
    input  logic [mem_pkg::DATA_W-1:0]  imme,
    input  logic                        mem_read,
    input  logic                        mem_write,
    input  logic                        mem_to_reg,
    input  mem_pkg::mem_sel_e           mem_sel,
    input  logic                        lui_sig,
    input  logic [mem_pkg::HALF_W-1:0]  sram_rdata,
    output logic [mem_pkg::SRAM_AW-1:0] sram_addr,
    output logic [mem_pkg::HALF_W-1:0]  sram_wdata,
    output logic [mem_pkg::BE_W-1:0]    sram_be,
    output logic                        ce,
    output logic                        we,
    output logic                        oe,
    output logic [mem_pkg::DATA_W-1:0]  dout,
    output logic                        stall,
    output logic                        mem_done
);
    import mem_pkg::*;

    sram_op_e          op;
    logic              half_sel;
    logic              capture;
    logic [WORD_AW-1:0] word_addr;
    logic [HALF_W-1:0] half_wdata;
    logic [BE_W-1:0]   half_be;
    logic [DATA_W-1:0] load_word;

    // word aligned only, byte offset dropped
    assign word_addr = alu_result[WORD_LSB +: WORD_AW];

    // sequencing of the one or two half accesses
    mem_ctrl mem_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_sel   (mem_sel),
        .op        (op),
        .half_sel  (half_sel),
        .capture   (capture),
        .stall     (stall),
        .mem_done  (mem_done)
    );

    store_format store_format_inst (
        .din        (din),
        .mem_sel    (mem_sel),
        .half_sel   (half_sel),
        .half_wdata (half_wdata),
        .half_be    (half_be)
    );

    // external bus registers and read capture
    sram_port sram_port_inst (
        .clk        (clk),
        .rst        (rst),
        .op         (op),
        .half_sel   (half_sel),
        .capture    (capture),
        .word_addr  (word_addr),
        .half_wdata (half_wdata),
        .half_be    (half_be),
        .sram_rdata (sram_rdata),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_be    (sram_be),
        .ce         (ce),
        .we         (we),
        .oe         (oe),
        .load_word  (load_word)
    );

    load_format load_format_inst (
        .load_word  (load_word),
        .alu_result (alu_result),
        .imme       (imme),
        .mem_sel    (mem_sel),
        .mem_to_reg (mem_to_reg),
        .lui_sig    (lui_sig),
        .dout       (dout)
    );

endmodule

/* tests/sram_model.sv */
`timescale 1ns/10ps

module sram_model (
    input  logic                        clk,
    input  logic [mem_pkg::SRAM_AW-1:0] sram_addr,
    input  logic [mem_pkg::HALF_W-1:0]  sram_wdata,
    input  logic [mem_pkg::BE_W-1:0]    sram_be,     // bit 0 = low byte
    input  logic                        ce,
    input  logic                        we,
    input  logic                        oe,
    output logic [mem_pkg::HALF_W-1:0]  sram_rdata   // async read data
);
    import mem_pkg::*;

    localparam int DEPTH = 1 << SRAM_AW;  // one entry per 16-bit half

    logic [HALF_W-1:0] mem [0:DEPTH-1];

    // power-up contents, a pattern over the full address
    initial begin
        for (int i = 0; i < DEPTH; i++)
            mem[i] = HALF_W'(i ^ (i >> 4));
    end

    // write edge needs both ce and we, lanes gated by sram_be
    always @(posedge clk) begin
        if (ce && we) begin
            if (sram_be[0])
                mem[sram_addr][7:0] <= sram_wdata[7:0];
            if (sram_be[1])
                mem[sram_addr][15:8] <= sram_wdata[15:8];
        end
    end

    // read path is combinational, no clock involved
    assign sram_rdata = (ce && oe) ? mem[sram_addr] : '0;

endmodule

/* tests/tb_mem_stage.sv */
`timescale 1ns/10ps

module tb_mem_stage;
    import mem_pkg::*;

    localparam int TIMEOUT = 50;  // cycles allowed per wait

    logic               clk;
    logic               rst;
    logic [DATA_W-1:0]  alu_result;
    logic [DATA_W-1:0]  din;
    logic [DATA_W-1:0]  imme;
    logic               mem_read;
    logic               mem_write;
    logic               mem_to_reg;
    mem_sel_e           mem_sel;
    logic               lui_sig;
    logic [HALF_W-1:0]  sram_rdata;
    logic [SRAM_AW-1:0] sram_addr;
    logic [HALF_W-1:0]  sram_wdata;
    logic [BE_W-1:0]    sram_be;
    logic               ce;
    logic               we;
    logic               oe;
    logic [DATA_W-1:0]  dout;
    logic               stall;
    logic               mem_done;

    logic [HALF_W-1:0]  shadow [int unsigned];  // half address -> expected contents
    integer             seed;
    logic               done_q;                 // mem_done one cycle back

    mem_stage mem_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .alu_result (alu_result),
        .din        (din),
        .imme       (imme),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_to_reg (mem_to_reg),
        .mem_sel    (mem_sel),
        .lui_sig    (lui_sig),
        .sram_rdata (sram_rdata),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_be    (sram_be),
        .ce         (ce),
        .we         (we),
        .oe         (oe),
        .dout       (dout),
        .stall      (stall),
        .mem_done   (mem_done)
    );

    sram_model sram_model_inst (
        .clk        (clk),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_be    (sram_be),
        .ce         (ce),
        .we         (we),
        .oe         (oe),
        .sram_rdata (sram_rdata)
    );

    always #20 clk = ~clk;  // 40 ns period

    task automatic stop_on_error();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        assert (cond) else begin
            $display("Error: %s", what);
            stop_on_error();
        end
    endtask

    // cycles from sampled request to mem_done
    // one setup and one strobe per half, plus the done cycle
    function automatic int expected_latency(input mem_sel_e sel);
        case (sel)
            SEL_NONE: return 1;
            SEL_WORD: return 5;
            default:  return 3;
        endcase
    endfunction

    // word address bits plus half select
    function automatic int unsigned half_key(input logic [DATA_W-1:0] addr, input logic hi);
        return {addr[WORD_LSB +: SRAM_AW-1], hi};
    endfunction

    function automatic void shadow_write(input mem_sel_e sel, input logic [DATA_W-1:0] addr,
                                         input logic [DATA_W-1:0] data);
        logic [HALF_W-1:0] old;
        old = shadow.exists(half_key(addr, 1'b0)) ? shadow[half_key(addr, 1'b0)] : '0;
        case (sel)
            SEL_BYTE: shadow[half_key(addr, 1'b0)] = {old[15:8], data[7:0]};  // low lane only
            SEL_HALF: shadow[half_key(addr, 1'b0)] = data[15:0];
            SEL_WORD: begin
                shadow[half_key(addr, 1'b0)] = data[15:0];
                shadow[half_key(addr, 1'b1)] = data[31:16];
            end
            default: ;  // SEL_NONE writes nothing
        endcase
    endfunction

    // zero-extended by size
    function automatic logic [DATA_W-1:0] expected_load(input mem_sel_e sel,
                                                        input logic [DATA_W-1:0] addr);
        logic [HALF_W-1:0] lo;
        logic [HALF_W-1:0] hi;
        lo = shadow[half_key(addr, 1'b0)];
        hi = (sel == SEL_WORD) ? shadow[half_key(addr, 1'b1)] : '0;
        case (sel)
            SEL_BYTE: return {24'h0, lo[7:0]};
            SEL_HALF: return {16'h0, lo};
            SEL_WORD: return {hi, lo};
            default:  return '0;
        endcase
    endfunction

    // one request held until mem_done
    // latency, stall and bus address checked on the way
    task automatic run_access(input string name, input bit write, input mem_sel_e sel,
                              input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
                              output logic [DATA_W-1:0] result);
        int cycles;
        int halves;
        bit done_seen;
        cycles    = 0;
        halves    = 0;
        done_seen = 0;
        @(negedge clk);
        mem_read   = !write;
        mem_write  = write;
        mem_sel    = sel;
        alu_result = addr;
        din        = data;
        mem_to_reg = !write;
        lui_sig    = 1'b0;
        while (!done_seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (ce) begin  // strobe cycle of one half
                check_value({name, " sram_addr"}, half_key(addr, halves[0]), sram_addr);
                halves++;
            end
            if (mem_done)
                done_seen = 1;
            else
                check_true(stall, {name, ": stall low while the access is pending"});
        end
        if (!done_seen) begin
            $display("Error: %s timed out waiting for mem_done", name);
            stop_on_error();
        end
        check_value({name, " latency"}, expected_latency(sel), cycles);
        check_value({name, " halves"}, (sel == SEL_WORD) ? 2 : (sel == SEL_NONE ? 0 : 1),
                    halves);
        check_true(!stall, {name, ": stall still high in the mem_done cycle"});
        result = dout;  // valid in the done cycle
        mem_read   = 1'b0;  // drop request right after done
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
    endtask

    task automatic store(input string name, input mem_sel_e sel,
                         input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] ignored;
        run_access(name, 1'b1, sel, addr, data, ignored);
        shadow_write(sel, addr, data);
    endtask

    task automatic load(input string name, input mem_sel_e sel, input logic [DATA_W-1:0] addr);
        logic [DATA_W-1:0] got;
        run_access(name, 1'b0, sel, addr, '0, got);
        check_value(name, expected_load(sel, addr), got);
    endtask

    // cycle-level bus rules sampled mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            assert (!(mem_done && done_q)) else begin
                $display("Error: mem_done held high for more than one cycle");
                stop_on_error();
            end
            assert (ce || (!we && !oe)) else begin
                $display("Error: we or oe active without ce");
                stop_on_error();
            end
            assert (!(we && oe)) else begin
                $display("Error: we and oe active together");
                stop_on_error();
            end
            done_q <= mem_done;
        end
    end

    initial begin
        logic [DATA_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] result;
        clk        = 1'b0;
        rst        = 1'b1;
        alu_result = '0;
        din        = '0;
        imme       = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_to_reg = 1'b0;
        mem_sel    = SEL_NONE;
        lui_sig    = 1'b0;
        seed       = 5;
        repeat (3) @(negedge clk);  // 3 reset cycles
        rst = 1'b0;

        @(negedge clk);
        check_true(!ce && !we && !oe, "bus strobes active after reset");
        check_true(!stall && !mem_done, "stall or mem_done high after reset");

        // word store then word load at the same address
        for (int i = 0; i < 4; i++) begin
            addr = $random(seed);
            data = $random(seed);
            store("word_store", SEL_WORD, addr, data);
            load("word_load", SEL_WORD, addr);
        end

        // partial stores over a known word
        for (int i = 0; i < 3; i++) begin
            addr = $random(seed);
            data = $random(seed);
            store("word_fill", SEL_WORD, addr, data);
            data = $random(seed);
            store("byte_store", SEL_BYTE, addr, data);
            load("word_after_byte", SEL_WORD, addr);
            load("byte_load", SEL_BYTE, addr);
            data = $random(seed);
            store("half_store", SEL_HALF, addr, data);
            load("word_after_half", SEL_WORD, addr);
            load("half_load", SEL_HALF, addr);
        end

        // SEL_NONE finishes in one cycle with nothing on the bus
        run_access("none_write", 1'b1, SEL_NONE, addr, data, result);
        check_true(!ce, "ce active for a SEL_NONE access");
        check_value("none_write", addr, result);  // alu result passes through

        // pass-through writeback of alu result or upper immediate
        for (int i = 0; i < 6; i++) begin
            @(negedge clk);
            alu_result = $random(seed);
            imme       = $random(seed);
            lui_sig    = i[0];
            mem_to_reg = 1'b0;
            mem_sel    = mem_sel_e'(i[1:0]);
            @(negedge clk);
            if (lui_sig)
                check_value("no_access_lui", {imme[15:0], 16'h0}, dout);
            else
                check_value("no_access_alu", alu_result, dout);
            check_true(!ce, "ce active with no request");
            check_true(!stall, "stall high with no request");
        end

        $display("** PASS **");
        $finish;
    end

endmodule

/* mem_stage.f */
src/mem_pkg.sv
src/mem_ctrl.sv
src/store_format.sv
src/sram_port.sv
src/load_format.sv
src/mem_stage.sv
tests/sram_model.sv
tests/tb_mem_stage.sv
